// ==== hw/user_wr_defs.svh ====
`ifndef USER_WR_DEFS_SVH
`define USER_WR_DEFS_SVH

// ---------------------------------------------------------------------------
// Write-side stream mux sizing
// ---------------------------------------------------------------------------

// User source streams sharing the output
`define USER_WR_N_DESTS 4

// Stream data width in bits, keep is this over eight
`define USER_WR_DATA_BITS 64

// Command length field, counted as beats minus one
`define USER_WR_LEN_BITS 8

// Routing command queue entries
`define USER_WR_CMD_DEPTH 4

`endif

// ==== hw/user_wr_pkg.sv ====
`include "user_wr_defs.svh"

package user_wr_pkg;

  // Source index width, never below one bit
  localparam int DEST_BITS = (`USER_WR_N_DESTS > 1) ? $clog2(`USER_WR_N_DESTS) : 1;

  // -------------------------------------------------------------------------
  // Raw command word
  // -------------------------------------------------------------------------
  // Index in the top byte, length in the low bits
  // Anything between is reserved and ignored
  typedef struct packed {
    logic [7:0]                       dest;
    logic [23-`USER_WR_LEN_BITS:0]    rsvd;
    logic [`USER_WR_LEN_BITS-1:0]     len;
  } cmd_word_t;

  // -------------------------------------------------------------------------
  // Decoded routing command
  // -------------------------------------------------------------------------
  // Only in-range indices ever get this far
  typedef struct packed {
    logic [DEST_BITS-1:0]             dest;
    logic [`USER_WR_LEN_BITS-1:0]     len;
  } mux_cmd_t;

endpackage

// ==== hw/user_wr_intf.sv ====
`timescale 1ns/10ps

`include "user_wr_defs.svh"

// ---------------------------------------------------------------------------
// Plain AXI4-Stream beat
// ---------------------------------------------------------------------------
interface axis_if;
  logic                               tvalid;
  logic                               tready;
  logic [`USER_WR_DATA_BITS-1:0]      tdata;
  logic [`USER_WR_DATA_BITS/8-1:0]    tkeep;
  logic                               tlast;

  // Source side
  modport m (output tvalid, tdata, tkeep, tlast, input tready);
  // Sink side
  modport s (input tvalid, tdata, tkeep, tlast, output tready);
endinterface

// ---------------------------------------------------------------------------
// Decoded command handoff, decoder to mux
// ---------------------------------------------------------------------------
interface mux_cmd_if;
  import user_wr_pkg::*;

  logic       valid;
  logic       ready;
  mux_cmd_t   cmd;

  modport m (output valid, cmd, input ready);
  modport s (input valid, cmd, output ready);
endinterface

// ---------------------------------------------------------------------------
// Muxed beat with command markers, mux to output stage
// ---------------------------------------------------------------------------
interface wr_beat_if;
  import user_wr_pkg::*;

  logic                               tvalid;
  logic                               tready;
  logic [`USER_WR_DATA_BITS-1:0]      tdata;
  logic [`USER_WR_DATA_BITS/8-1:0]    tkeep;
  logic                               tlast;
  // Last beat counted for the command
  logic                               cmd_end;
  // Source of the running command
  logic [DEST_BITS-1:0]               dest;

  modport m (output tvalid, tdata, tkeep, tlast, cmd_end, dest, input tready);
  modport s (input tvalid, tdata, tkeep, tlast, cmd_end, dest, output tready);
endinterface

// ==== hw/mux_cmd_decode.sv ====
`timescale 1ns/10ps

`include "user_wr_defs.svh"

module mux_cmd_decode (
  input  logic                    aclk,
  input  logic                    aresetn,

  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  user_wr_pkg::cmd_word_t  cmd_word,
  output logic                    cmd_err,

  mux_cmd_if.m                    mux
);

  import user_wr_pkg::*;

  localparam int DEPTH     = `USER_WR_CMD_DEPTH;
  localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS  = $clog2(DEPTH + 1);

  // Queue storage
  mux_cmd_t               cmd_mem [DEPTH];

  logic [PTR_BITS-1:0]    wr_ptr;
  logic [PTR_BITS-1:0]    rd_ptr;
  logic [CNT_BITS-1:0]    fill;

  logic                   accept;
  logic                   in_range;
  logic                   push;
  logic                   pop;
  mux_cmd_t               cmd_dec;

  // -------------------------------------------------------------------------
  // Field split and range check
  // -------------------------------------------------------------------------
  // Full index byte compared, so high garbage is caught too
  assign in_range = (cmd_word.dest < `USER_WR_N_DESTS);

  assign cmd_dec.dest = cmd_word.dest[DEST_BITS-1:0];
  assign cmd_dec.len  = cmd_word.len;

  // Handshakes
  assign cmd_ready = (fill != CNT_BITS'(DEPTH));
  assign accept    = cmd_valid & cmd_ready;
  assign push      = accept & in_range;
  assign pop       = mux.valid & mux.ready;

  // Head of queue straight to the mux
  assign mux.valid = (fill != '0);
  assign mux.cmd   = cmd_mem[rd_ptr];

  // -------------------------------------------------------------------------
  // Queue control
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      cmd_err <= 1'b0;
    end else begin
      // One-cycle pulse for a dropped command
      cmd_err <= accept & ~in_range;

      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end

      // Push and pop together leave the fill alone
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Entry write
  always_ff @(posedge aclk) begin
    if (push) begin
      cmd_mem[wr_ptr] <= cmd_dec;
    end
  end

endmodule

// ==== hw/axis_mux_user_wr.sv ====
`timescale 1ns/10ps

`include "user_wr_defs.svh"

module axis_mux_user_wr (
  input  logic    aclk,
  input  logic    aresetn,

  mux_cmd_if.s    mux,

  axis_if.s       s_axis [`USER_WR_N_DESTS],
  wr_beat_if.m    m_beat
);

  import user_wr_pkg::*;

  localparam int N_DESTS   = `USER_WR_N_DESTS;
  localparam int KEEP_BITS = `USER_WR_DATA_BITS / 8;

  // Two-state FSM, idle or forwarding one source
  typedef enum logic [0:0] {ST_IDLE, ST_MUX} state_t;

  state_t                           state_q;
  state_t                           state_d;

  logic [DEST_BITS-1:0]             dest_q;
  logic [DEST_BITS-1:0]             dest_d;
  logic [`USER_WR_LEN_BITS-1:0]     cnt_q;
  logic [`USER_WR_LEN_BITS-1:0]     cnt_d;

  logic                             beat_fire;
  logic                             tr_done;

  // -------------------------------------------------------------------------
  // Source unpack
  // -------------------------------------------------------------------------
  logic [N_DESTS-1:0]                               src_tvalid;
  logic [N_DESTS-1:0]                               src_tready;
  logic [N_DESTS-1:0][`USER_WR_DATA_BITS-1:0]       src_tdata;
  logic [N_DESTS-1:0][KEEP_BITS-1:0]                src_tkeep;
  logic [N_DESTS-1:0]                               src_tlast;

  for (genvar i = 0; i < N_DESTS; i++) begin : g_src
    assign src_tvalid[i]    = s_axis[i].tvalid;
    assign src_tdata[i]     = s_axis[i].tdata;
    assign src_tkeep[i]     = s_axis[i].tkeep;
    assign src_tlast[i]     = s_axis[i].tlast;
    assign s_axis[i].tready = src_tready[i];
  end

  // -------------------------------------------------------------------------
  // Data path mux
  // -------------------------------------------------------------------------
  always_comb begin
    // Ready only to the selected source
    for (int i = 0; i < N_DESTS; i++) begin
      src_tready[i] = (state_q == ST_MUX) && (dest_q == DEST_BITS'(i)) && m_beat.tready;
    end

    if (state_q == ST_MUX) begin
      m_beat.tvalid = src_tvalid[dest_q];
      m_beat.tdata  = src_tdata[dest_q];
      m_beat.tkeep  = src_tkeep[dest_q];
      m_beat.tlast  = src_tlast[dest_q];
    end else begin
      m_beat.tvalid = 1'b0;
      m_beat.tdata  = '0;
      m_beat.tkeep  = '0;
      m_beat.tlast  = 1'b0;
    end
  end

  // End marker on the zero count, tlast from the source is not trusted
  assign m_beat.cmd_end = (state_q == ST_MUX) && (cnt_q == '0);
  assign m_beat.dest    = dest_q;

  assign beat_fire = m_beat.tvalid & m_beat.tready;
  assign tr_done   = m_beat.cmd_end & beat_fire;

  // -------------------------------------------------------------------------
  // State registers
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      dest_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      dest_q  <= dest_d;
      cnt_q   <= cnt_d;
    end
  end

  // Next state and command load
  always_comb begin
    state_d   = state_q;
    dest_d    = dest_q;
    cnt_d     = cnt_q;
    mux.ready = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (mux.valid) begin
          mux.ready = 1'b1;
          dest_d    = mux.cmd.dest;
          cnt_d     = mux.cmd.len;
          state_d   = ST_MUX;
        end
      end

      ST_MUX: begin
        if (tr_done) begin
          // Back-to-back load, no idle cycle between commands
          if (mux.valid) begin
            mux.ready = 1'b1;
            dest_d    = mux.cmd.dest;
            cnt_d     = mux.cmd.len;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (beat_fire) begin
          cnt_d = cnt_q - 1'b1;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

endmodule

// ==== hw/wr_out_stage.sv ====
`timescale 1ns/10ps

`include "user_wr_defs.svh"

module wr_out_stage (
  input  logic                                aclk,
  input  logic                                aresetn,

  wr_beat_if.s                                s_beat,

  output logic                                m_axis_tvalid,
  input  logic                                m_axis_tready,
  output logic [`USER_WR_DATA_BITS-1:0]       m_axis_tdata,
  output logic [`USER_WR_DATA_BITS/8-1:0]     m_axis_tkeep,
  output logic                                m_axis_tlast,

  output logic                                done_valid,
  output logic [user_wr_pkg::DEST_BITS-1:0]   done_dest,
  output logic                                done_err
);

  import user_wr_pkg::*;

  localparam int KEEP_BITS = `USER_WR_DATA_BITS / 8;
  // data, keep, tlast, cmd_end, dest, error
  localparam int BEAT_BITS = `USER_WR_DATA_BITS + KEEP_BITS + 3 + DEST_BITS;

  logic [BEAT_BITS-1:0]   in_beat;
  logic [BEAT_BITS-1:0]   main_q;
  logic [BEAT_BITS-1:0]   skid_q;
  logic                   skid_valid;

  logic                   in_fire;
  logic                   out_fire;
  logic                   load_ok;

  // Error bit running for the command at the input side
  logic                   err_acc;
  logic                   in_err;

  logic                   out_end;
  logic [DEST_BITS-1:0]   out_dest;
  logic                   out_err;

  // -------------------------------------------------------------------------
  // Input side
  // -------------------------------------------------------------------------
  // Ready comes from a register, so m_axis_tready stays off the source path
  assign s_beat.tready = ~skid_valid;
  assign in_fire       = s_beat.tvalid & s_beat.tready;

  // tlast early, or missing on the end beat
  assign in_err  = err_acc | (s_beat.tlast != s_beat.cmd_end);
  assign in_beat = {s_beat.tdata, s_beat.tkeep, s_beat.tlast,
                    s_beat.cmd_end, s_beat.dest, in_err};

  // -------------------------------------------------------------------------
  // Output side
  // -------------------------------------------------------------------------
  assign {m_axis_tdata, m_axis_tkeep, m_axis_tlast, out_end, out_dest, out_err} = main_q;

  assign out_fire = m_axis_tvalid & m_axis_tready;
  // Main register free or draining this cycle
  assign load_ok  = ~m_axis_tvalid | m_axis_tready;

  // Control flags
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_axis_tvalid <= 1'b0;
      skid_valid    <= 1'b0;
      err_acc       <= 1'b0;
      done_valid    <= 1'b0;
    end else begin
      if (load_ok) begin
        // Skid entry first to keep beat order
        m_axis_tvalid <= skid_valid | in_fire;
        skid_valid    <= 1'b0;
      end else if (in_fire) begin
        skid_valid <= 1'b1;
      end

      // Sticky error, cleared once the end beat is taken
      if (in_fire) begin
        err_acc <= s_beat.cmd_end ? 1'b0 : in_err;
      end

      done_valid <= out_fire & out_end;
    end
  end

  // Payload registers
  always_ff @(posedge aclk) begin
    if (load_ok) begin
      if (skid_valid) begin
        main_q <= skid_q;
      end else if (in_fire) begin
        main_q <= in_beat;
      end
    end else if (in_fire) begin
      skid_q <= in_beat;
    end

    // Completion report for the departing end beat
    if (out_fire && out_end) begin
      done_dest <= out_dest;
      done_err  <= out_err;
    end
  end

endmodule

// ==== hw/user_wr_top.sv ====
`timescale 1ns/10ps

`include "user_wr_defs.svh"

module user_wr_top (
  input  logic                                                  aclk,
  input  logic                                                  aresetn,

  // Routing commands
  input  logic                                                  cmd_valid,
  output logic                                                  cmd_ready,
  input  user_wr_pkg::cmd_word_t                                cmd_word,
  output logic                                                  cmd_err,

  // User sources, packed one slice per stream
  input  logic [`USER_WR_N_DESTS-1:0]                           s_axis_tvalid,
  output logic [`USER_WR_N_DESTS-1:0]                           s_axis_tready,
  input  logic [`USER_WR_N_DESTS-1:0][`USER_WR_DATA_BITS-1:0]   s_axis_tdata,
  input  logic [`USER_WR_N_DESTS-1:0][`USER_WR_DATA_BITS/8-1:0] s_axis_tkeep,
  input  logic [`USER_WR_N_DESTS-1:0]                           s_axis_tlast,

  // Merged output
  output logic                                                  m_axis_tvalid,
  input  logic                                                  m_axis_tready,
  output logic [`USER_WR_DATA_BITS-1:0]                         m_axis_tdata,
  output logic [`USER_WR_DATA_BITS/8-1:0]                       m_axis_tkeep,
  output logic                                                  m_axis_tlast,

  // Per-command completion
  output logic                                                  done_valid,
  output logic [user_wr_pkg::DEST_BITS-1:0]                     done_dest,
  output logic                                                  done_err
);

  // ---------------------------------------------------------------------------
  // Interface instances
  // ---------------------------------------------------------------------------
  axis_if     src_if [`USER_WR_N_DESTS] ();
  mux_cmd_if  cmd_if ();
  wr_beat_if  beat_if ();

  // Flat source ports into the interface array
  for (genvar i = 0; i < `USER_WR_N_DESTS; i++) begin : g_src
    assign src_if[i].tvalid = s_axis_tvalid[i];
    assign src_if[i].tdata  = s_axis_tdata[i];
    assign src_if[i].tkeep  = s_axis_tkeep[i];
    assign src_if[i].tlast  = s_axis_tlast[i];
    assign s_axis_tready[i] = src_if[i].tready;
  end

  // ---------------------------------------------------------------------------
  // Stages
  // ---------------------------------------------------------------------------
  mux_cmd_decode u_decode (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_word  (cmd_word),
    .cmd_err   (cmd_err),
    .mux       (cmd_if)
  );

  axis_mux_user_wr u_mux (
    .aclk    (aclk),
    .aresetn (aresetn),
    .mux     (cmd_if),
    .s_axis  (src_if),
    .m_beat  (beat_if)
  );

  wr_out_stage u_out (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_beat        (beat_if),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast),
    .done_valid    (done_valid),
    .done_dest     (done_dest),
    .done_err      (done_err)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

// ---------------------------------------------------------------------------
// Clock and reset source for the testbench
// ---------------------------------------------------------------------------
module tb_clock_gen (
  output logic aclk,
  output logic aresetn
);

  // 10 ns period
  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // Reset held low over the first four rising edges
  initial begin
    aresetn = 1'b0;
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
  end

endmodule

// ==== testbench/tb_user_wr_top.sv ====
`timescale 1ns/10ps

`include "user_wr_defs.svh"

module tb_user_wr_top;

  import user_wr_pkg::*;

  localparam int N_DESTS        = `USER_WR_N_DESTS;
  localparam int DATA_BITS      = `USER_WR_DATA_BITS;
  localparam int KEEP_BITS      = DATA_BITS / 8;
  localparam int N_CMDS         = 60;
  localparam int MAX_BEATS      = 512;
  localparam int TIMEOUT_CYCLES = 40 * N_CMDS + 200;

  logic                                  aclk;
  logic                                  aresetn;

  // DUT ports
  logic                                  cmd_valid;
  logic                                  cmd_ready;
  logic [31:0]                           cmd_word;
  logic                                  cmd_err;
  logic [N_DESTS-1:0]                    s_axis_tvalid;
  logic [N_DESTS-1:0]                    s_axis_tready;
  logic [N_DESTS-1:0][DATA_BITS-1:0]     s_axis_tdata;
  logic [N_DESTS-1:0][KEEP_BITS-1:0]     s_axis_tkeep;
  logic [N_DESTS-1:0]                    s_axis_tlast;
  logic                                  m_axis_tvalid;
  logic                                  m_axis_tready;
  logic [DATA_BITS-1:0]                  m_axis_tdata;
  logic [KEEP_BITS-1:0]                  m_axis_tkeep;
  logic                                  m_axis_tlast;
  logic                                  done_valid;
  logic [DEST_BITS-1:0]                  done_dest;
  logic                                  done_err;

  // Command list and per-source beat lists, built once at time zero
  logic [31:0]                           rng_state;
  logic [31:0]                           cmd_list [N_CMDS];
  logic [DATA_BITS-1:0]                  src_data [N_DESTS][MAX_BEATS];
  logic [KEEP_BITS-1:0]                  src_keep [N_DESTS][MAX_BEATS];
  logic                                  src_last [N_DESTS][MAX_BEATS];
  int                                    src_cnt [N_DESTS];
  int                                    src_ptr [N_DESTS];

  // Model of the merged stream, source beats in command order
  logic [DATA_BITS-1:0]                  exp_data [MAX_BEATS];
  logic [KEEP_BITS-1:0]                  exp_keep [MAX_BEATS];
  logic                                  exp_last [MAX_BEATS];
  logic                                  exp_end  [MAX_BEATS];
  int                                    exp_cnt;
  int                                    exp_ptr;

  // Expected completion reports
  logic [DEST_BITS-1:0]                  exp_done_dest [N_CMDS];
  logic                                  exp_done_err  [N_CMDS];
  int                                    n_valid;
  int                                    n_bad;
  int                                    done_ptr;

  int                                    cmd_idx;
  int                                    err_cnt;
  int                                    cycle_cnt;
  logic                                  rst_prev;
  logic                                  err_pend;
  logic                                  done_pend;

  tb_clock_gen u_clk (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  user_wr_top dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_word      (cmd_word),
    .cmd_err       (cmd_err),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast),
    .done_valid    (done_valid),
    .done_dest     (done_dest),
    .done_err      (done_err)
  );

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus lists and model
  // ---------------------------------------------------------------------------
  initial begin : build_stimulus
    logic [31:0]          r;
    logic [31:0]          r_flt;
    logic [31:0]          keep_r;
    logic [7:0]           dest;
    logic [7:0]           len;
    logic                 fault;
    logic                 early;
    logic                 last;
    logic [DATA_BITS-1:0] data;
    int                   d;

    rng_state     = 32'h610bc794;
    cmd_valid     = 1'b0;
    cmd_word      = '0;
    s_axis_tvalid = '0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tlast  = '0;
    m_axis_tready = 1'b0;
    exp_cnt       = 0;
    exp_ptr       = 0;
    n_valid       = 0;
    n_bad         = 0;
    done_ptr      = 0;
    cmd_idx       = 0;
    err_cnt       = 0;
    cycle_cnt     = 0;
    rst_prev      = 1'b0;
    err_pend      = 1'b0;
    done_pend     = 1'b0;
    for (int i = 0; i < N_DESTS; i++) begin
      src_cnt[i] = 0;
      src_ptr[i] = 0;
    end

    for (int c = 0; c < N_CMDS; c++) begin
      r   = xorshift32();
      len = {5'b0, r[2:0]};
      // About one word in eight names a source that does not exist
      if (r[5:3] == 3'd0) begin
        dest  = 8'(N_DESTS + (r[15:8] % (256 - N_DESTS)));
        n_bad = n_bad + 1;
      end else begin
        dest = 8'(r[15:8] % N_DESTS);
      end
      // Reserved bits get random junk
      cmd_list[c] = {dest, r[31:16], len};

      if (dest < N_DESTS) begin
        r_flt = xorshift32();
        fault = (r_flt % 5 == 0);
        // Early tlast on the first beat, else tlast missing on the end beat
        early = fault && r_flt[8] && (len != 0);
        d     = dest;
        exp_done_dest[n_valid] = dest[DEST_BITS-1:0];
        exp_done_err[n_valid]  = fault;
        n_valid = n_valid + 1;

        for (int b = 0; b <= len; b++) begin
          for (int w = 0; w < DATA_BITS / 32; w++) begin
            data[w*32 +: 32] = xorshift32();
          end
          keep_r = xorshift32();
          last   = (b == len);
          if (fault) begin
            last = early ? ((b == 0) || (b == len)) : 1'b0;
          end
          src_data[d][src_cnt[d]] = data;
          src_keep[d][src_cnt[d]] = keep_r[KEEP_BITS-1:0];
          src_last[d][src_cnt[d]] = last;
          src_cnt[d] = src_cnt[d] + 1;
          exp_data[exp_cnt] = data;
          exp_keep[exp_cnt] = keep_r[KEEP_BITS-1:0];
          exp_last[exp_cnt] = last;
          exp_end[exp_cnt]  = (b == len);
          exp_cnt = exp_cnt + 1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Drivers for the command port, the sources and m_axis_tready
  // ---------------------------------------------------------------------------
  always @(posedge aclk) begin
    if (!aresetn) begin
      cmd_valid     <= 1'b0;
      s_axis_tvalid <= '0;
      m_axis_tready <= 1'b0;
    end else begin
      // Next word once the current one is taken, with random gaps
      if (cmd_valid && cmd_ready) begin
        cmd_idx = cmd_idx + 1;
      end
      if (!cmd_valid || cmd_ready) begin
        if ((cmd_idx < N_CMDS) && (xorshift32() % 4 != 0)) begin
          cmd_valid <= 1'b1;
          cmd_word  <= cmd_list[cmd_idx];
        end else begin
          cmd_valid <= 1'b0;
        end
      end

      // Each source offers its own beat list in order
      for (int i = 0; i < N_DESTS; i++) begin
        if (s_axis_tvalid[i] && s_axis_tready[i]) begin
          src_ptr[i] = src_ptr[i] + 1;
        end
        if (!s_axis_tvalid[i] || s_axis_tready[i]) begin
          if ((src_ptr[i] < src_cnt[i]) && (xorshift32() % 4 != 0)) begin
            s_axis_tvalid[i] <= 1'b1;
            s_axis_tdata[i]  <= src_data[i][src_ptr[i]];
            s_axis_tkeep[i]  <= src_keep[i][src_ptr[i]];
            s_axis_tlast[i]  <= src_last[i][src_ptr[i]];
          end else begin
            s_axis_tvalid[i] <= 1'b0;
          end
        end
      end

      // Sink stalls about one cycle in four
      m_axis_tready <= (xorshift32() % 4 != 0);
    end
  end

  // ---------------------------------------------------------------------------
  // Monitor and checks
  // ---------------------------------------------------------------------------
  always @(posedge aclk) begin : monitor
    logic done_next;

    done_next = 1'b0;
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run hung before all commands completed");
      $display("Simulation FAILED");
      $fatal(1, "cycle limit reached");
    end else begin
      // Values left by a reset edge
      if (rst_prev) begin
        check_value(m_axis_tvalid, 1'b0, "m_axis_tvalid in reset");
        check_value(done_valid, 1'b0, "done_valid in reset");
        check_value(cmd_err, 1'b0, "cmd_err in reset");
        check_value(s_axis_tready, '0, "s_axis_tready in reset");
        check_value(cmd_ready, 1'b1, "cmd_ready after reset");
      end

      if (aresetn) begin
        // One cmd_err pulse the cycle after a bad word is taken
        check_value(cmd_err, err_pend, "cmd_err pulse");
        if (cmd_err) begin
          err_cnt = err_cnt + 1;
        end
        err_pend = cmd_valid && cmd_ready && (cmd_word[31:24] >= N_DESTS);

        // Merged stream against the model
        if (m_axis_tvalid && m_axis_tready) begin
          check_value(exp_ptr < exp_cnt, 1'b1, "output beat beyond the model");
          check_value(m_axis_tdata, exp_data[exp_ptr], "m_axis_tdata");
          check_value(m_axis_tkeep, exp_keep[exp_ptr], "m_axis_tkeep");
          check_value(m_axis_tlast, exp_last[exp_ptr], "m_axis_tlast");
          done_next = exp_end[exp_ptr];
          exp_ptr   = exp_ptr + 1;
        end

        // Report follows the end beat by one cycle
        check_value(done_valid, done_pend, "done_valid timing");
        if (done_valid) begin
          check_value(done_dest, exp_done_dest[done_ptr], "done_dest");
          check_value(done_err, exp_done_err[done_ptr], "done_err");
          done_ptr = done_ptr + 1;
        end
        done_pend = done_next;
      end else begin
        err_pend  = 1'b0;
        done_pend = 1'b0;
      end
      rst_prev = !aresetn;
    end
  end

  // ---------------------------------------------------------------------------
  // End of run
  // ---------------------------------------------------------------------------
  initial begin : finish_run
    @(posedge aresetn);
    wait (done_ptr == n_valid);
    // Settle time, late or extra beats still hit the monitor
    repeat (20) @(posedge aclk);
    check_value(cmd_idx, N_CMDS, "commands taken by the decoder");
    check_value(exp_ptr, exp_cnt, "output beat count");
    check_value(err_cnt, n_bad, "cmd_err pulse count");
    for (int i = 0; i < N_DESTS; i++) begin
      check_value(src_ptr[i], src_cnt[i], "source beats drained");
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/user_wr_pkg.sv
hw/user_wr_intf.sv
hw/mux_cmd_decode.sv
hw/axis_mux_user_wr.sv
hw/wr_out_stage.sv
hw/user_wr_top.sv
testbench/tb_clock_gen.sv
testbench/tb_user_wr_top.sv
